// File: rtl/decode_pkg.sv
// opcodes, select encodings and packet types used by the decode RTL and its testbench
package decode_pkg;

  ////////////////////////////////////////////////////////////
  // alpha major opcodes, inst[31:26]
  ////////////////////////////////////////////////////////////
  localparam logic [5:0] pal_inst = 6'h00; // call_pal, only halt survives
  localparam logic [5:0] lda_inst = 6'h08; // load address
  localparam logic [5:0] inta_grp = 6'h10; // add, sub, compares
  localparam logic [5:0] intl_grp = 6'h11; // logicals
  localparam logic [5:0] ints_grp = 6'h12; // shifts
  localparam logic [5:0] intm_grp = 6'h13; // multiply
  localparam logic [5:0] jsr_grp  = 6'h1a; // jmp, jsr, ret, jsr_co
  localparam logic [5:0] ldq_inst = 6'h29;
  localparam logic [5:0] stq_inst = 6'h2d;
  localparam logic [5:0] br_inst  = 6'h30;
  localparam logic [5:0] bsr_inst = 6'h34;

  // fp branches sit among the integer ones, rejected by name
  localparam logic [5:0] fbeq_inst = 6'h31;
  localparam logic [5:0] fblt_inst = 6'h32;
  localparam logic [5:0] fble_inst = 6'h33;
  localparam logic [5:0] fbne_inst = 6'h35;
  localparam logic [5:0] fbge_inst = 6'h36;
  localparam logic [5:0] fbgt_inst = 6'h37;

  localparam logic [2:0] cbr_grp = 3'b111; // opcode[5:3] of blbc .. bgt

  ////////////////////////////////////////////////////////////
  // operate function field, inst[11:5]
  ////////////////////////////////////////////////////////////
  localparam logic [6:0] addq_fn   = 7'h20; // inta
  localparam logic [6:0] subq_fn   = 7'h29;
  localparam logic [6:0] cmpeq_fn  = 7'h2d;
  localparam logic [6:0] cmpult_fn = 7'h1d;
  localparam logic [6:0] cmpule_fn = 7'h3d;
  localparam logic [6:0] cmplt_fn  = 7'h4d;
  localparam logic [6:0] cmple_fn  = 7'h6d;
  localparam logic [6:0] and_fn    = 7'h00; // intl
  localparam logic [6:0] bic_fn    = 7'h08;
  localparam logic [6:0] bis_fn    = 7'h20;
  localparam logic [6:0] ornot_fn  = 7'h28;
  localparam logic [6:0] xor_fn    = 7'h40;
  localparam logic [6:0] eqv_fn    = 7'h48;
  localparam logic [6:0] srl_fn    = 7'h34; // ints
  localparam logic [6:0] sll_fn    = 7'h39;
  localparam logic [6:0] sra_fn    = 7'h3c;
  localparam logic [6:0] mulq_fn   = 7'h20; // intm

  localparam logic [25:0] halt_code = 26'h0555; // pal payload for halt
  localparam logic [4:0]  zero_reg  = 5'd31;    // r31, write is a no-op

  ////////////////////////////////////////////////////////////
  // datapath select encodings
  ////////////////////////////////////////////////////////////
  typedef enum logic [4:0] {
    alu_addq, alu_subq, alu_cmpeq, alu_cmpult, alu_cmpule, alu_cmplt,
    alu_cmple, alu_and, alu_bic, alu_bis, alu_ornot, alu_xor, alu_eqv,
    alu_srl, alu_sll, alu_sra, alu_mulq
  } alu_func_e;

  typedef enum logic [1:0] {
    opa_is_rega, opa_is_mem_disp, opa_is_npc, opa_is_not3
  } opa_sel_e;

  typedef enum logic [1:0] {
    opb_is_regb, opb_is_alu_imm, opb_is_br_disp
  } opb_sel_e;

  typedef enum logic [1:0] {
    dest_none, dest_is_rega, dest_is_regc
  } dest_sel_e;

  // operate format
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] ra;
    logic [4:0] rb;     // literal[7:3] when is_lit
    logic [2:0] lit_lo; // literal[2:0], sbz for register form
    logic       is_lit;
    logic [6:0] func;
    logic [4:0] rc;
  } op_fmt_t;

  // memory format, branches reuse it with a wider disp
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [15:0] disp;
  } mem_fmt_t;

  typedef union packed {
    op_fmt_t  op;
    mem_fmt_t mem;
  } inst_u;

  typedef struct packed {
    inst_u inst;
    logic  valid;
  } fetch_slot_t;

  // one decoded slot as it crosses id/ex
  typedef struct packed {
    opa_sel_e  opa_sel;
    opb_sel_e  opb_sel;
    alu_func_e alu_func;
    logic [4:0] dest_idx; // zero_reg when nothing written
    logic [4:0] ra_idx;
    logic [4:0] rb_idx;
    logic       rd_mem;
    logic       wr_mem;
    logic       cond_br;
    logic       uncond_br;
    logic       halt;
    logic       illegal;
    logic       valid;
  } id_pkt_t;

endpackage

// File: rtl/inst_decoder.sv
// combinational decode of one alpha word into alu selects, memory and branch flags
`timescale 1ns/1ps

module inst_decoder (
  input  decode_pkg::inst_u     inst,
  input  logic                  valid_in,  // low gives the noop controls
  output decode_pkg::opa_sel_e  opa_sel,
  output decode_pkg::opb_sel_e  opb_sel,
  output decode_pkg::alu_func_e alu_func,
  output decode_pkg::dest_sel_e dest_sel,
  output logic                  rd_mem,
  output logic                  wr_mem,
  output logic                  cond_br,
  output logic                  uncond_br,
  output logic                  halt,
  output logic                  illegal,
  output logic                  valid     // issuable when neither halt nor illegal
);

  ////////////////////////////////////////////////////////////
  // decode pla
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    // noop defaults that every group overrides as needed
    opa_sel   = decode_pkg::opa_is_rega;
    opb_sel   = decode_pkg::opb_is_regb;
    alu_func  = decode_pkg::alu_addq;
    dest_sel  = decode_pkg::dest_none;
    rd_mem    = 1'b0;
    wr_mem    = 1'b0;
    cond_br   = 1'b0;
    uncond_br = 1'b0;
    halt      = 1'b0;
    illegal   = 1'b0;

    if (valid_in)
    begin
      case (inst.op.opcode)
        decode_pkg::pal_inst:
          // only the halt payload is implemented
          if ({inst.mem.ra, inst.mem.rb, inst.mem.disp} == decode_pkg::halt_code)
            halt = 1'b1;
          else
            illegal = 1'b1;

        decode_pkg::inta_grp, decode_pkg::intl_grp,
        decode_pkg::ints_grp, decode_pkg::intm_grp:
        begin
          opb_sel  = inst.op.is_lit ? decode_pkg::opb_is_alu_imm
                                    : decode_pkg::opb_is_regb;
          dest_sel = decode_pkg::dest_is_regc; // operates write rc
          case (inst.op.opcode)
            decode_pkg::inta_grp:
              case (inst.op.func)
                decode_pkg::addq_fn:   alu_func = decode_pkg::alu_addq;
                decode_pkg::subq_fn:   alu_func = decode_pkg::alu_subq;
                decode_pkg::cmpeq_fn:  alu_func = decode_pkg::alu_cmpeq;
                decode_pkg::cmpult_fn: alu_func = decode_pkg::alu_cmpult;
                decode_pkg::cmpule_fn: alu_func = decode_pkg::alu_cmpule;
                decode_pkg::cmplt_fn:  alu_func = decode_pkg::alu_cmplt;
                decode_pkg::cmple_fn:  alu_func = decode_pkg::alu_cmple;
                default:               illegal  = 1'b1; // longword and scaled forms
              endcase
            decode_pkg::intl_grp:
              case (inst.op.func)
                decode_pkg::and_fn:    alu_func = decode_pkg::alu_and;
                decode_pkg::bic_fn:    alu_func = decode_pkg::alu_bic;
                decode_pkg::bis_fn:    alu_func = decode_pkg::alu_bis;
                decode_pkg::ornot_fn:  alu_func = decode_pkg::alu_ornot;
                decode_pkg::xor_fn:    alu_func = decode_pkg::alu_xor;
                decode_pkg::eqv_fn:    alu_func = decode_pkg::alu_eqv;
                default:               illegal  = 1'b1; // cmov family
              endcase
            decode_pkg::ints_grp:
              case (inst.op.func)
                decode_pkg::srl_fn:    alu_func = decode_pkg::alu_srl;
                decode_pkg::sll_fn:    alu_func = decode_pkg::alu_sll;
                decode_pkg::sra_fn:    alu_func = decode_pkg::alu_sra;
                default:               illegal  = 1'b1; // byte manipulation
              endcase
            decode_pkg::intm_grp:
              if (inst.op.func == decode_pkg::mulq_fn)
                alu_func = decode_pkg::alu_mulq;
              else
                illegal = 1'b1;
          endcase
        end

        decode_pkg::lda_inst, decode_pkg::ldq_inst, decode_pkg::stq_inst:
        begin
          // effective address = disp + regb
          opa_sel  = decode_pkg::opa_is_mem_disp;
          alu_func = decode_pkg::alu_addq;
          dest_sel = decode_pkg::dest_is_rega;
          if (inst.mem.opcode == decode_pkg::ldq_inst)
            rd_mem = 1'b1;
          else if (inst.mem.opcode == decode_pkg::stq_inst)
          begin
            wr_mem   = 1'b1;
            dest_sel = decode_pkg::dest_none; // stores write no register
          end
        end

        decode_pkg::jsr_grp:
        begin
          // all four jumps target regb & ~3
          opa_sel   = decode_pkg::opa_is_not3;
          alu_func  = decode_pkg::alu_and;
          dest_sel  = decode_pkg::dest_is_rega; // return link
          uncond_br = 1'b1;
        end

        decode_pkg::br_inst, decode_pkg::bsr_inst:
        begin
          opa_sel   = decode_pkg::opa_is_npc;
          opb_sel   = decode_pkg::opb_is_br_disp;
          dest_sel  = decode_pkg::dest_is_rega; // link npc
          uncond_br = 1'b1;
        end

        decode_pkg::fbeq_inst, decode_pkg::fblt_inst, decode_pkg::fble_inst,
        decode_pkg::fbne_inst, decode_pkg::fbge_inst, decode_pkg::fbgt_inst:
          illegal = 1'b1; // no fp unit

        default:
          if (inst.op.opcode[5:3] == decode_pkg::cbr_grp)
          begin
            opa_sel = decode_pkg::opa_is_npc;
            opb_sel = decode_pkg::opb_is_br_disp;
            cond_br = 1'b1;
          end
          else
            illegal = 1'b1; // fp operates and misc plus the loads and stores not kept
      endcase
    end

    valid = valid_in && !illegal && !halt;
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    // memory, branch, halt and illegal come from separate arms
    a_flag_excl: assert ($onehot0({rd_mem, wr_mem, cond_br, uncond_br, halt, illegal}))
      else $error("decoder raises more than one memory, branch, halt or illegal flag");
    // every issuable word writes a register, stores or branches on a condition
    a_valid_class: assert (!valid || dest_sel != decode_pkg::dest_none || wr_mem || cond_br)
      else $error("decoder marks a word valid that has no effect");
  end

endmodule

// File: rtl/id_stage.sv
// decodes both fetch slots, picks destination indices and kills slot 2 behind a halt
`timescale 1ns/1ps

module id_stage (
  input  decode_pkg::fetch_slot_t slot_1, // older instruction
  input  decode_pkg::fetch_slot_t slot_2,
  output decode_pkg::id_pkt_t     dec_1,
  output decode_pkg::id_pkt_t     dec_2
);

  decode_pkg::dest_sel_e dest_sel_1;
  decode_pkg::dest_sel_e dest_sel_2;
  logic                  valid_in_2; // slot 2 after the ordering rule

  // dest mux, r31 when nothing is written back
  function automatic logic [4:0] dest_index(input decode_pkg::dest_sel_e sel,
                                            input decode_pkg::inst_u     inst);
    case (sel)
      decode_pkg::dest_is_regc: return inst.op.rc;
      decode_pkg::dest_is_rega: return inst.op.ra;
      default:                  return decode_pkg::zero_reg;
    endcase
  endfunction

  // nothing issues past a halt or illegal in slot 1
  assign valid_in_2 = slot_2.valid && !(slot_1.valid && (dec_1.halt || dec_1.illegal));

  ////////////////////////////////////////////////////////////
  // slot 1
  ////////////////////////////////////////////////////////////
  inst_decoder u_dec_1 (
    .inst      (slot_1.inst),
    .valid_in  (slot_1.valid),
    .opa_sel   (dec_1.opa_sel),
    .opb_sel   (dec_1.opb_sel),
    .alu_func  (dec_1.alu_func),
    .dest_sel  (dest_sel_1),
    .rd_mem    (dec_1.rd_mem),
    .wr_mem    (dec_1.wr_mem),
    .cond_br   (dec_1.cond_br),
    .uncond_br (dec_1.uncond_br),
    .halt      (dec_1.halt),
    .illegal   (dec_1.illegal),
    .valid     (dec_1.valid)
  );

  assign dec_1.ra_idx   = slot_1.inst.mem.ra; // same bits in every format
  assign dec_1.rb_idx   = slot_1.inst.mem.rb;
  assign dec_1.dest_idx = dest_index(dest_sel_1, slot_1.inst);

  ////////////////////////////////////////////////////////////
  // slot 2
  ////////////////////////////////////////////////////////////
  inst_decoder u_dec_2 (
    .inst      (slot_2.inst),
    .valid_in  (valid_in_2),
    .opa_sel   (dec_2.opa_sel),
    .opb_sel   (dec_2.opb_sel),
    .alu_func  (dec_2.alu_func),
    .dest_sel  (dest_sel_2),
    .rd_mem    (dec_2.rd_mem),
    .wr_mem    (dec_2.wr_mem),
    .cond_br   (dec_2.cond_br),
    .uncond_br (dec_2.uncond_br),
    .halt      (dec_2.halt),
    .illegal   (dec_2.illegal),
    .valid     (dec_2.valid)
  );

  assign dec_2.ra_idx   = slot_2.inst.mem.ra;
  assign dec_2.rb_idx   = slot_2.inst.mem.rb;
  assign dec_2.dest_idx = dest_index(dest_sel_2, slot_2.inst);

endmodule

// File: rtl/id_ex_reg.sv
// id/ex pipeline register for the decoded pair, holds on stall and drops flags on flush
`timescale 1ns/1ps

module id_ex_reg (
  input  logic                clock,
  input  logic                rst_n,
  input  logic                stall, // hold, fetch side holds too
  input  logic                flush, // wins over stall
  input  decode_pkg::id_pkt_t dec_1,
  input  decode_pkg::id_pkt_t dec_2,
  output decode_pkg::id_pkt_t ex_1,
  output decode_pkg::id_pkt_t ex_2
);

  always_ff @(posedge clock)
  begin
    if (!rst_n)
    begin
      ex_1 <= '0;
      ex_2 <= '0;
    end
    else if (flush)
    begin
      // squash both slots, payload left as is
      ex_1.valid   <= 1'b0;
      ex_1.halt    <= 1'b0;
      ex_1.illegal <= 1'b0;
      ex_2.valid   <= 1'b0;
      ex_2.halt    <= 1'b0;
      ex_2.illegal <= 1'b0;
    end
    else if (!stall)
    begin
      ex_1 <= dec_1;
      ex_2 <= dec_2;
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////
  a_clear: assert property (@(posedge clock)
    (!rst_n || flush) |=> !(ex_1.valid || ex_2.valid || ex_1.halt || ex_2.halt ||
                            ex_1.illegal || ex_2.illegal))
    else $error("id/ex still live one cycle after reset or flush");

  a_hold: assert property (@(posedge clock) disable iff (!rst_n)
    (stall && !flush) |=> ($stable(ex_1) && $stable(ex_2)))
    else $error("id/ex changed under stall");

endmodule

// File: rtl/decode_top.sv
// two-wide decode top, fetch slots in and registered id/ex packets out one cycle later
`timescale 1ns/1ps

module decode_top (
  input  logic                    clock,
  input  logic                    rst_n,
  input  logic                    stall,  // from execute
  input  logic                    flush,  // from execute, mispredict or trap
  input  decode_pkg::fetch_slot_t slot_1,
  input  decode_pkg::fetch_slot_t slot_2,
  output decode_pkg::id_pkt_t     ex_1,
  output decode_pkg::id_pkt_t     ex_2
);

  decode_pkg::id_pkt_t dec_1; // comb decode, slot 1
  decode_pkg::id_pkt_t dec_2; // comb decode, slot 2 after kill

  // decode, 0 cycles
  id_stage u_id_stage (
    .slot_1 (slot_1),
    .slot_2 (slot_2),
    .dec_1  (dec_1),
    .dec_2  (dec_2)
  );

  // pipeline register, 1 cycle
  id_ex_reg u_id_ex_reg (
    .clock (clock),
    .rst_n (rst_n),
    .stall (stall),
    .flush (flush),
    .dec_1 (dec_1),
    .dec_2 (dec_2),
    .ex_1  (ex_1),
    .ex_2  (ex_2)
  );

endmodule

// File: verif/tb_clk_gen.sv
// testbench clock and reset source, 10 ns clock with rst_n low for the first 5 cycles
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clock,
  output logic rst_n
);

  initial
  begin
    clock = 1'b0;
    rst_n = 1'b0;
    repeat (5) @(posedge clock); // 5 cycles in reset
    @(negedge clock);
    rst_n <= 1'b1; // released on a falling edge like all tb drives
  end

  always #5 clock = ~clock;

endmodule

// File: verif/decode_tb.sv
// table-driven testbench for decode_top, applies slot pairs with stall and flush and checks id/ex
`timescale 1ns/1ps

module decode_tb;

  // one row of the stimulus table
  typedef struct packed {
    decode_pkg::fetch_slot_t s1;
    decode_pkg::fetch_slot_t s2;
    logic                    stall;
    logic                    flush;
    decode_pkg::id_pkt_t     e1; // expected ex_1 after the next rising edge
    decode_pkg::id_pkt_t     e2;
  } entry_t;

  logic                    clock;
  logic                    rst_n;
  logic                    stall;
  logic                    flush;
  decode_pkg::fetch_slot_t slot_1;
  decode_pkg::fetch_slot_t slot_2;
  decode_pkg::id_pkt_t     ex_1;
  decode_pkg::id_pkt_t     ex_2;

  entry_t              tbl[$];
  decode_pkg::id_pkt_t last_1; // what id/ex should hold after the last row
  decode_pkg::id_pkt_t last_2;
  int                  errors = 0;
  int                  checks = 0;
  int unsigned         cycle_cnt = 0;

  tb_clk_gen u_clk_gen (
    .clock (clock),
    .rst_n (rst_n)
  );

  decode_top u_dut (
    .clock  (clock),
    .rst_n  (rst_n),
    .stall  (stall),
    .flush  (flush),
    .slot_1 (slot_1),
    .slot_2 (slot_2),
    .ex_1   (ex_1),
    .ex_2   (ex_2)
  );

  always @(posedge clock)
    cycle_cnt <= cycle_cnt + 1;

  ////////////////////////////////////////////////////////////
  // word and packet builders
  ////////////////////////////////////////////////////////////
  function automatic logic [4:0] rand_reg();
    return 5'($urandom());
  endfunction

  function automatic decode_pkg::inst_u make_op_word(input logic [5:0] opc,
                                                     input logic [6:0] fn,
                                                     input logic       lit);
    decode_pkg::inst_u w;
    w.op.opcode = opc;
    w.op.ra     = rand_reg();
    w.op.rb     = rand_reg(); // upper literal bits in literal form
    w.op.lit_lo = lit ? 3'($urandom()) : 3'b000;
    w.op.is_lit = lit;
    w.op.func   = fn;
    w.op.rc     = rand_reg();
    return w;
  endfunction

  function automatic decode_pkg::inst_u make_mem_word(input logic [5:0]  opc,
                                                      input logic [25:0] rest);
    decode_pkg::inst_u w;
    w.mem.opcode = opc;
    {w.mem.ra, w.mem.rb, w.mem.disp} = rest; // ra, rb, disp
    return w;
  endfunction

  function automatic decode_pkg::fetch_slot_t make_slot(input decode_pkg::inst_u w,
                                                        input logic              v);
    decode_pkg::fetch_slot_t s;
    s.inst  = w;
    s.valid = v;
    return s;
  endfunction

  // controls of a slot that does nothing, indices still from the word
  function automatic decode_pkg::id_pkt_t noop_pkt(input decode_pkg::inst_u w);
    decode_pkg::id_pkt_t p;
    p          = '0;
    p.opa_sel  = decode_pkg::opa_is_rega;
    p.opb_sel  = decode_pkg::opb_is_regb;
    p.alu_func = decode_pkg::alu_addq;
    p.dest_idx = decode_pkg::zero_reg;
    p.ra_idx   = w.mem.ra;
    p.rb_idx   = w.mem.rb;
    return p;
  endfunction

  function automatic decode_pkg::id_pkt_t flushed(input decode_pkg::id_pkt_t p);
    decode_pkg::id_pkt_t f;
    f         = p;
    f.valid   = 1'b0;
    f.halt    = 1'b0;
    f.illegal = 1'b0;
    return f;
  endfunction

  ////////////////////////////////////////////////////////////
  // table construction
  ////////////////////////////////////////////////////////////
  task automatic push_entry(input decode_pkg::fetch_slot_t s1, input decode_pkg::fetch_slot_t s2,
                            input logic st, input logic fl,
                            input decode_pkg::id_pkt_t e1, input decode_pkg::id_pkt_t e2);
    entry_t e;
    e.s1    = s1;
    e.s2    = s2;
    e.stall = st;
    e.flush = fl;
    e.e1    = e1;
    e.e2    = e2;
    tbl.push_back(e);
    last_1 = e1;
    last_2 = e2;
  endtask

  // register form in slot 1, literal form in slot 2
  task automatic add_operate_case(input logic [5:0] opc, input logic [6:0] fn,
                                  input decode_pkg::alu_func_e alu);
    decode_pkg::inst_u   w1;
    decode_pkg::inst_u   w2;
    decode_pkg::id_pkt_t e1;
    decode_pkg::id_pkt_t e2;
    w1          = make_op_word(opc, fn, 1'b0);
    w2          = make_op_word(opc, fn, 1'b1);
    e1          = noop_pkt(w1);
    e1.alu_func = alu;
    e1.dest_idx = w1.op.rc;
    e1.valid    = 1'b1;
    e2          = noop_pkt(w2);
    e2.alu_func = alu;
    e2.opb_sel  = decode_pkg::opb_is_alu_imm;
    e2.dest_idx = w2.op.rc;
    e2.valid    = 1'b1;
    push_entry(make_slot(w1, 1'b1), make_slot(w2, 1'b1), 1'b0, 1'b0, e1, e2);
  endtask

  // last row's pair waits n stalled cycles before it loads
  task automatic stall_before_last(input int n);
    entry_t x;
    entry_t prev;
    x    = tbl.pop_back();
    prev = tbl[$];
    repeat (n)
      push_entry(x.s1, x.s2, 1'b1, 1'b0, prev.e1, prev.e2);
    push_entry(x.s1, x.s2, 1'b0, 1'b0, x.e1, x.e2);
  endtask

  task automatic add_flush(input logic st);
    push_entry(tbl[$].s1, tbl[$].s2, st, 1'b1, flushed(last_1), flushed(last_2));
  endtask

  task automatic add_pair(input decode_pkg::inst_u w1, input logic v1,
                          input decode_pkg::inst_u w2, input logic v2,
                          input decode_pkg::id_pkt_t e1, input decode_pkg::id_pkt_t e2);
    push_entry(make_slot(w1, v1), make_slot(w2, v2), 1'b0, 1'b0, e1, e2);
  endtask

  task automatic build_table();
    decode_pkg::inst_u   w1;
    decode_pkg::inst_u   w2;
    decode_pkg::id_pkt_t e1;
    decode_pkg::id_pkt_t e2;

    // every integer operate, both operand b forms
    add_operate_case(decode_pkg::inta_grp, decode_pkg::addq_fn,   decode_pkg::alu_addq);
    add_operate_case(decode_pkg::inta_grp, decode_pkg::subq_fn,   decode_pkg::alu_subq);
    add_operate_case(decode_pkg::inta_grp, decode_pkg::cmpeq_fn,  decode_pkg::alu_cmpeq);
    add_operate_case(decode_pkg::inta_grp, decode_pkg::cmpult_fn, decode_pkg::alu_cmpult);
    add_operate_case(decode_pkg::inta_grp, decode_pkg::cmpule_fn, decode_pkg::alu_cmpule);
    add_operate_case(decode_pkg::inta_grp, decode_pkg::cmplt_fn,  decode_pkg::alu_cmplt);
    add_operate_case(decode_pkg::inta_grp, decode_pkg::cmple_fn,  decode_pkg::alu_cmple);
    add_operate_case(decode_pkg::intl_grp, decode_pkg::and_fn,    decode_pkg::alu_and);
    add_operate_case(decode_pkg::intl_grp, decode_pkg::bic_fn,    decode_pkg::alu_bic);
    add_operate_case(decode_pkg::intl_grp, decode_pkg::bis_fn,    decode_pkg::alu_bis);
    add_operate_case(decode_pkg::intl_grp, decode_pkg::ornot_fn,  decode_pkg::alu_ornot);
    add_operate_case(decode_pkg::intl_grp, decode_pkg::xor_fn,    decode_pkg::alu_xor);
    add_operate_case(decode_pkg::intl_grp, decode_pkg::eqv_fn,    decode_pkg::alu_eqv);
    add_operate_case(decode_pkg::ints_grp, decode_pkg::srl_fn,    decode_pkg::alu_srl);
    add_operate_case(decode_pkg::ints_grp, decode_pkg::sll_fn,    decode_pkg::alu_sll);
    add_operate_case(decode_pkg::ints_grp, decode_pkg::sra_fn,    decode_pkg::alu_sra);
    add_operate_case(decode_pkg::intm_grp, decode_pkg::mulq_fn,   decode_pkg::alu_mulq);

    // lda and ldq
    w1 = make_mem_word(decode_pkg::lda_inst, 26'($urandom()));
    w2 = make_mem_word(decode_pkg::ldq_inst, 26'($urandom()));
    e1 = noop_pkt(w1);
    e1.opa_sel = decode_pkg::opa_is_mem_disp;
    e1.dest_idx = w1.mem.ra;
    e1.valid = 1'b1;
    e2 = noop_pkt(w2);
    e2.opa_sel = decode_pkg::opa_is_mem_disp;
    e2.dest_idx = w2.mem.ra;
    e2.rd_mem = 1'b1;
    e2.valid = 1'b1;
    add_pair(w1, 1'b1, w2, 1'b1, e1, e2);

    // stq and jsr, held for 3 stalled cycles first
    w1 = make_mem_word(decode_pkg::stq_inst, 26'($urandom()));
    w2 = make_mem_word(decode_pkg::jsr_grp, 26'($urandom()));
    e1 = noop_pkt(w1);
    e1.opa_sel = decode_pkg::opa_is_mem_disp;
    e1.wr_mem = 1'b1;
    e1.valid = 1'b1;
    e2 = noop_pkt(w2);
    e2.opa_sel = decode_pkg::opa_is_not3;
    e2.alu_func = decode_pkg::alu_and;
    e2.dest_idx = w2.mem.ra;
    e2.uncond_br = 1'b1;
    e2.valid = 1'b1;
    add_pair(w1, 1'b1, w2, 1'b1, e1, e2);
    stall_before_last(3);

    // br and bsr link ra
    w1 = make_mem_word(decode_pkg::br_inst, 26'($urandom()));
    w2 = make_mem_word(decode_pkg::bsr_inst, 26'($urandom()));
    e1 = noop_pkt(w1);
    e1.opa_sel = decode_pkg::opa_is_npc;
    e1.opb_sel = decode_pkg::opb_is_br_disp;
    e1.dest_idx = w1.mem.ra;
    e1.uncond_br = 1'b1;
    e1.valid = 1'b1;
    e2 = e1;
    e2.ra_idx = w2.mem.ra;
    e2.rb_idx = w2.mem.rb;
    e2.dest_idx = w2.mem.ra;
    add_pair(w1, 1'b1, w2, 1'b1, e1, e2);

    // beq and bgt, no link
    w1 = make_mem_word(6'h39, 26'($urandom()));
    w2 = make_mem_word(6'h3f, 26'($urandom()));
    e1 = noop_pkt(w1);
    e1.opa_sel = decode_pkg::opa_is_npc;
    e1.opb_sel = decode_pkg::opb_is_br_disp;
    e1.cond_br = 1'b1;
    e1.valid = 1'b1;
    e2 = e1;
    e2.ra_idx = w2.mem.ra;
    e2.rb_idx = w2.mem.rb;
    add_pair(w1, 1'b1, w2, 1'b1, e1, e2);

    // halt kills a legal addq, then flush under stall
    w1 = make_mem_word(decode_pkg::pal_inst, decode_pkg::halt_code);
    w2 = make_op_word(decode_pkg::inta_grp, decode_pkg::addq_fn, 1'b0);
    e1 = noop_pkt(w1);
    e1.halt = 1'b1;
    add_pair(w1, 1'b1, w2, 1'b1, e1, noop_pkt(w2));
    add_flush(1'b1);

    // fp operate opcode kills ldq
    w1 = make_mem_word(6'h16, 26'($urandom()));
    w2 = make_mem_word(decode_pkg::ldq_inst, 26'($urandom()));
    e1 = noop_pkt(w1);
    e1.illegal = 1'b1;
    add_pair(w1, 1'b1, w2, 1'b1, e1, noop_pkt(w2));

    // cmov is not kept, operate selects already taken
    w1 = make_op_word(decode_pkg::intl_grp, 7'h14, 1'b0);
    w2 = make_mem_word(decode_pkg::stq_inst, 26'($urandom()));
    e1 = noop_pkt(w1);
    e1.dest_idx = w1.op.rc;
    e1.illegal = 1'b1;
    add_pair(w1, 1'b1, w2, 1'b1, e1, noop_pkt(w2));
    add_flush(1'b0);

    // illegal misc word in slot 2 only
    add_operate_case(decode_pkg::inta_grp, decode_pkg::addq_fn, decode_pkg::alu_addq);
    w1 = tbl[$].s1.inst;
    e1 = tbl[$].e1;
    void'(tbl.pop_back());
    w2 = make_mem_word(6'h18, 26'($urandom()));
    e2 = noop_pkt(w2);
    e2.illegal = 1'b1;
    add_pair(w1, 1'b1, w2, 1'b1, e1, e2);

    // invalid halt in slot 1 leaves slot 2 alone
    w1 = make_mem_word(decode_pkg::pal_inst, decode_pkg::halt_code);
    w2 = make_mem_word(decode_pkg::fbeq_inst, 26'($urandom()));
    e2 = noop_pkt(w2);
    e2.illegal = 1'b1;
    add_pair(w1, 1'b0, w2, 1'b1, noop_pkt(w1), e2);

    // both slots idle
    w1 = make_mem_word(decode_pkg::ldq_inst, 26'($urandom()));
    w2 = make_mem_word(decode_pkg::br_inst, 26'($urandom()));
    add_pair(w1, 1'b0, w2, 1'b0, noop_pkt(w1), noop_pkt(w2));
  endtask

  ////////////////////////////////////////////////////////////
  // checks and waits
  ////////////////////////////////////////////////////////////
  task automatic check_pkt(input string name, input decode_pkg::id_pkt_t got,
                           input decode_pkg::id_pkt_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_valid(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR at %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // back on a falling edge with one rising edge behind us
  task automatic step_cycle();
    int unsigned start;
    int          guard;
    start = cycle_cnt;
    guard = 0;
    while (cycle_cnt == start && guard < 20)
    begin
      @(negedge clock);
      guard++;
    end
    if (cycle_cnt == start)
    begin
      $display("no rising clock edge seen within 20 falling edges");
      $display("Regression failed");
      $finish;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial
  begin
    int guard;
    stall  = 1'b0;
    flush  = 1'b0;
    slot_1 = '0;
    slot_2 = '0;
    void'($urandom(32'hb2af36da));
    build_table();

    // outputs stay invalid through reset and the first edge after it
    guard = 0;
    while (rst_n !== 1'b1 && guard < 20)
    begin
      @(negedge clock);
      guard++;
      check_valid("ex_1.valid", ex_1.valid, 1'b0);
      check_valid("ex_2.valid", ex_2.valid, 1'b0);
    end
    if (rst_n !== 1'b1)
    begin
      $display("reset was never released");
      $display("Regression failed");
      $finish;
    end

    foreach (tbl[i])
    begin
      slot_1 = tbl[i].s1; // falling edge drive
      slot_2 = tbl[i].s2;
      stall  = tbl[i].stall;
      flush  = tbl[i].flush;
      step_cycle();
      check_pkt($sformatf("ex_1 row %0d", i), ex_1, tbl[i].e1);
      check_pkt($sformatf("ex_2 row %0d", i), ex_2, tbl[i].e2);
      if (tbl[i].flush)
      begin
        check_valid("ex_1.valid", ex_1.valid, 1'b0);
        check_valid("ex_2.valid", ex_2.valid, 1'b0);
      end
    end
    stall = 1'b0;
    flush = 1'b0;

    $display("rows %0d, checks %0d, errors %0d", tbl.size(), checks, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  // guard against a dead clock
  initial
  begin
    #1ms;
    $display("simulation ran past its time limit");
    $display("Regression failed");
    $finish;
  end

endmodule

// File: flist.f
rtl/decode_pkg.sv
rtl/inst_decoder.sv
rtl/id_stage.sv
rtl/id_ex_reg.sv
rtl/decode_top.sv
verif/tb_clk_gen.sv
verif/decode_tb.sv

// File: run.sh
#!/bin/sh
# build and run the decode testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module decode_tb -o decode_sim
./obj_dir/decode_sim > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log; then
  exit 1
fi
exit 0
